// ==== Makefile ====
TOP := csr_file_tb

.PHONY: all lint clean

all: obj_dir/V$(TOP)
	./obj_dir/V$(TOP) | tee sim.log
	grep -q "TEST PASS" sim.log

obj_dir/V$(TOP): csr_file.f src/*.sv bench/*.sv
	verilator --binary --timing --assert -Wno-fatal -f csr_file.f --top-module $(TOP)

lint:
	verilator --lint-only --timing -Wall -f csr_file.f --top-module csr_file

clean:
	rm -rf obj_dir sim.log

// ==== bench/csr_cases.txt ====
# op addr data expected, all hex; SAVE data is random, RD of SAVE, TID, EENTRY uses the model
# EXC: addr=ecode data=era exp=plv_o; ERT exp=plv_o; IRQ data=level exp=has_int_o; WAIT data=cycles exp=has_int_o
GROUP write_readback
WRA 30 0 0
WRB 33 0 0
WRA 40 1234abcd 0
WRA c 1c0007ff 0
RD 30 0 0
RD 33 0 0
RD 40 0 0
RD c 0 0
WRAB 31 0 0
RD 31 0 0
GROUP exception_entry
WRA 0 7 0
EXC 1c 1c008000 0
RD 1 0 7
RD 0 0 0
RD 5 0 1c0000
RD 6 0 1c008000
GROUP exception_return
ERT 0 0 3
RD 0 0 7
GROUP interrupts
WRA 5 3 0
WRA 4 3 0
WAIT 0 1 1
WRA 4 0 0
WAIT 0 1 0
IRQ 0 1ff 0
RD 5 0 1c07ff
IRQ 0 0 0
GROUP timer
WRA 41 d 0
WAIT 0 c 0
RD 5 0 1c0003
RD 5 0 1c0803
RD 42 0 ffffffff
WRA 44 1 0
RD 5 0 1c0003
WRA 41 f 0
WAIT 0 c 0
RD 5 0 1c0003
RD 5 0 1c0803
WRA 44 1 0
RD 5 0 1c0003
WAIT 0 a 0
RD 5 0 1c0803
WRA 41 0 0
GROUP stable_counter
WAIT 0 8 0
WRA 43 fffffffb 0
RD 43 0 fffffffb
WAIT 0 5 0

// ==== bench/csr_file_tb.sv ====
module csr_file_tb
    import csr_pkg::*;
();

    timeunit 1ns;
    timeprecision 100ps;

    typedef enum {
        OP_WRA, OP_WRB, OP_WRAB, OP_EXC, OP_ERT, OP_IRQ, OP_WAIT, OP_RD, OP_GROUP
    } op_e;

    logic                  clk;
    logic                  rst;
    csr_write_t            wr_a;
    csr_write_t            wr_b;
    trap_event_t           trap;
    logic [8:0]            hw_int;
    logic [CSR_ADDR_W-1:0] raddr;
    logic [CSR_W-1:0]      rdata;
    logic                  has_int;
    logic [1:0]            plv;
    logic [CSR_W-1:0]      eentry;
    logic [CSR_W-1:0]      era;
    logic [CSR_W-1:0]      tid;
    logic [63:0]           timer_64;

    op_e                   ops[$];
    string                 names[$];
    logic [31:0]           addrs[$];
    logic [31:0]           datas[$];
    logic [31:0]           exps[$];

    // expected state kept by the testbench
    logic [CSR_W-1:0]      model_reg [0:255];
    logic [CSR_W-1:0]      cntc_model;
    logic [CSR_W-1:0]      era_model;
    logic                  era_known;
    logic [63:0]           stable_model;

    int                    seed;
    int                    errors;
    int                    group_errors;
    int                    checks;
    int                    cycles;
    int                    cycle_limit;
    string                 group_name;

    csr_file u_csr_file (
        .clk        (clk),
        .rst        (rst),
        .wr_a_i     (wr_a),
        .wr_b_i     (wr_b),
        .trap_i     (trap),
        .hw_int_i   (hw_int),
        .raddr_i    (raddr),
        .rdata_o    (rdata),
        .has_int_o  (has_int),
        .plv_o      (plv),
        .eentry_o   (eentry),
        .era_o      (era),
        .tid_o      (tid),
        .timer_64_o (timer_64)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #2 clk = ~clk;
        end
    end

    // stable counter counts every edge out of reset
    always @(posedge clk) begin
        if (rst) begin
            stable_model <= '0;
        end else begin
            stable_model <= stable_model + 64'd1;
        end
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycle_limit > 0 && cycles >= cycle_limit) begin
            $display("timeout after %0d cycles, the case list did not finish", cycles);
            $display("TEST FAIL");
            $finish;
        end
    end

    task automatic check_value(input string name, input logic [63:0] got,
                               input logic [63:0] exp);
        checks++;
        assert (got === exp) else begin
            $display("FAILED at %0t: %s is %h, expected %h", $time, name, got, exp);
            errors++;
            group_errors++;
        end
    endtask

    function automatic bit is_save(input logic [31:0] addr);
        return addr[CSR_ADDR_W-1:0] inside {CSR_SAVE0, CSR_SAVE1, CSR_SAVE2, CSR_SAVE3};
    endfunction

    // registers that only change through CSR writes
    function automatic bit modelled(input logic [31:0] addr);
        return is_save(addr) || addr[CSR_ADDR_W-1:0] inside {CSR_TID, CSR_EENTRY};
    endfunction

    function automatic bit op_from_name(input string s, output op_e op);
        op = OP_WAIT;
        case (s)
            "WRA":   op = OP_WRA;
            "WRB":   op = OP_WRB;
            "WRAB":  op = OP_WRAB;
            "EXC":   op = OP_EXC;
            "ERT":   op = OP_ERT;
            "IRQ":   op = OP_IRQ;
            "WAIT":  op = OP_WAIT;
            "RD":    op = OP_RD;
            default: return 1'b0;
        endcase
        return 1'b1;
    endfunction

    task automatic add_case(input op_e op, input string name, input logic [31:0] a,
                            input logic [31:0] d, input logic [31:0] e);
        ops.push_back(op);
        names.push_back(name);
        addrs.push_back(a);
        datas.push_back(d);
        exps.push_back(e);
    endtask

    task automatic read_cases();
        int          fd;
        int          n;
        string       tok;
        string       rest;
        logic [31:0] a;
        logic [31:0] d;
        logic [31:0] e;
        op_e         op;
        fd = $fopen("bench/csr_cases.txt", "r");
        if (fd == 0) begin
            $display("could not open bench/csr_cases.txt");
            errors++;
            return;
        end
        while ($fscanf(fd, "%s", tok) == 1) begin
            if (tok.substr(0, 0) == "#") begin
                n = $fgets(rest, fd);
            end else if (tok == "GROUP") begin
                n = $fscanf(fd, "%s", rest);
                add_case(OP_GROUP, rest, '0, '0, '0);
            end else if ($fscanf(fd, "%h %h %h", a, d, e) == 3 && op_from_name(tok, op)) begin
                add_case(op, "", a, d, e);
            end else begin
                $display("case file line with op %s is malformed", tok);
                errors++;
            end
        end
        $fclose(fd);
    endtask

    task automatic finish_group();
        if (group_name != "") begin
            $display("group %s finished with %0d errors", group_name, group_errors);
        end
        group_errors = 0;
    endtask

    task automatic next_cycle();
        @(posedge clk);
        #1;
        wr_a  = '0;
        wr_b  = '0;
        trap  = '0;
        raddr = '0;
    endtask

    task automatic common_checks();
        check_value("timer_64_o", timer_64,
                    stable_model + {{32{cntc_model[31]}}, cntc_model});
        if (era_known) begin
            check_value("era_o", 64'(era), 64'(era_model));
        end
    endtask

    task automatic record_write(input logic [31:0] addr, input logic [31:0] data);
        if (addr[CSR_ADDR_W-1:0] == CSR_EENTRY) begin
            // entry point is 64-byte aligned
            model_reg[addr[7:0]] = data & 32'hffff_ffc0;
        end else if (addr[CSR_ADDR_W-1:0] == CSR_CNTC) begin
            cntc_model = data;
        end else begin
            model_reg[addr[7:0]] = data;
        end
    endtask

    task automatic run_case(input int i);
        logic [31:0] addr;
        logic [31:0] data;
        logic [31:0] exp;
        logic [63:0] t0;
        csr_write_t  w;
        addr = addrs[i];
        data = datas[i];
        exp  = exps[i];
        case (ops[i])
            OP_GROUP: begin
                finish_group();
                group_name = names[i];
            end
            OP_WRA, OP_WRB, OP_WRAB: begin
                if (is_save(addr)) begin
                    data = $random(seed);
                end
                w = '{we: 1'b1, addr: csr_addr_e'(addr[CSR_ADDR_W-1:0]), data: data};
                next_cycle();
                if (ops[i] == OP_WRB) begin
                    wr_b = w;
                end else begin
                    wr_a = w;
                end
                if (ops[i] == OP_WRAB) begin
                    // same target with other data on port 2
                    wr_b      = w;
                    wr_b.data = ~data;
                end
                @(negedge clk);
                common_checks();
                record_write(addr, data);
            end
            OP_EXC: begin
                next_cycle();
                trap.excp     = 1'b1;
                trap.ecode    = addr[ESTAT_ECODE_W-1:0];
                trap.esubcode = '0;
                trap.era      = data;
                @(negedge clk);
                common_checks();
                check_value("plv_o", 64'(plv), 64'(exp[1:0]));
                era_model = data;
                era_known = 1'b1;
            end
            OP_ERT: begin
                next_cycle();
                trap.ertn = 1'b1;
                @(negedge clk);
                common_checks();
                check_value("plv_o", 64'(plv), 64'(exp[1:0]));
            end
            OP_IRQ: begin
                next_cycle();
                hw_int = data[8:0];
                @(negedge clk);
                common_checks();
                check_value("has_int_o", 64'(has_int), 64'(exp[0]));
            end
            OP_WAIT: begin
                t0 = timer_64;
                repeat (data) begin
                    next_cycle();
                end
                @(negedge clk);
                common_checks();
                check_value("timer_64_o step", timer_64 - t0, 64'(data));
                check_value("has_int_o", 64'(has_int), 64'(exp[0]));
            end
            OP_RD: begin
                next_cycle();
                raddr = addr[CSR_ADDR_W-1:0];
                @(negedge clk);
                common_checks();
                if (modelled(addr)) begin
                    exp = model_reg[addr[7:0]];
                end
                check_value($sformatf("rdata_o[%h]", addr[CSR_ADDR_W-1:0]),
                            64'(rdata), 64'(exp));
                // side outputs follow the same registers
                if (addr[CSR_ADDR_W-1:0] == CSR_TID) begin
                    check_value("tid_o", 64'(tid), 64'(exp));
                end
                if (addr[CSR_ADDR_W-1:0] == CSR_EENTRY) begin
                    check_value("eentry_o", 64'(eentry), 64'(exp));
                end
            end
            default: ;
        endcase
    endtask

    initial begin
        int wait_total;
        seed         = 32'hd240_8c5b;
        errors       = 0;
        group_errors = 0;
        checks       = 0;
        cycles       = 0;
        cycle_limit  = 0;
        group_name   = "";
        rst          = 1'b1;
        wr_a         = '0;
        wr_b         = '0;
        trap         = '0;
        hw_int       = '0;
        raddr        = '0;
        cntc_model   = '0;
        era_model    = '0;
        era_known    = 1'b0;
        read_cases();
        wait_total = 0;
        foreach (ops[i]) begin
            if (ops[i] == OP_WAIT) begin
                wait_total += int'(datas[i]);
            end
        end
        cycle_limit = 2 * wait_total + 2 * ops.size();
        repeat (5) @(posedge clk);
        #1;
        rst = 1'b0;
        foreach (ops[i]) begin
            run_case(i);
        end
        finish_group();
        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

// ==== csr_file.f ====
src/csr_pkg.sv
src/csr_write_arbiter.sv
src/csr_trap_regs.sv
src/csr_timer.sv
src/csr_read_mux.sv
src/csr_file.sv
bench/csr_file_tb.sv

// ==== src/csr_file.sv ====
module csr_file
    import csr_pkg::*;
(
    input  logic                  clk,
    input  logic                  rst,

    input  csr_write_t            wr_a_i,
    input  csr_write_t            wr_b_i,
    input  trap_event_t           trap_i,
    input  logic [8:0]            hw_int_i,

    input  logic [CSR_ADDR_W-1:0] raddr_i,
    output logic [CSR_W-1:0]      rdata_o,

    output logic                  has_int_o,
    output logic [1:0]            plv_o,
    output logic [CSR_W-1:0]      eentry_o,
    output logic [CSR_W-1:0]      era_o,
    output logic [CSR_W-1:0]      tid_o,
    output logic [63:0]           timer_64_o
);

    csr_write_t   wr_sel;
    trap_state_t  trap_state;
    timer_state_t timer_state;

    csr_write_arbiter u_arbiter (
        .wr_a_i (wr_a_i),
        .wr_b_i (wr_b_i),
        .wr_o   (wr_sel)
    );

    csr_trap_regs u_trap_regs (
        .clk      (clk),
        .rst      (rst),
        .wr_i     (wr_sel),
        .trap_i   (trap_i),
        .hw_int_i (hw_int_i),
        .state_o  (trap_state)
    );

    csr_timer u_timer (
        .clk     (clk),
        .rst     (rst),
        .wr_i    (wr_sel),
        .state_o (timer_state)
    );

    csr_read_mux u_read_mux (
        .raddr_i   (raddr_i),
        .trap_i    (trap_state),
        .timer_i   (timer_state),
        .excp_i    (trap_i.excp),
        .ertn_i    (trap_i.ertn),
        .rdata_o   (rdata_o),
        .has_int_o (has_int_o),
        .plv_o     (plv_o),
        .stable_o  (timer_64_o)
    );

    // fetch side views
    assign eentry_o = trap_state.eentry;
    assign era_o    = trap_state.era;
    assign tid_o    = timer_state.tid;

endmodule

// ==== src/csr_pkg.sv ====
package csr_pkg;

    localparam int CSR_W      = 32;
    localparam int CSR_ADDR_W = 14;

    // kept CSR addresses act as the opcodes of the register file
    typedef enum logic [CSR_ADDR_W-1:0] {
        CSR_CRMD   = 14'h000,
        CSR_PRMD   = 14'h001,
        CSR_ECTL   = 14'h004,
        CSR_ESTAT  = 14'h005,
        CSR_ERA    = 14'h006,
        CSR_EENTRY = 14'h00c,
        CSR_SAVE0  = 14'h030,
        CSR_SAVE1  = 14'h031,
        CSR_SAVE2  = 14'h032,
        CSR_SAVE3  = 14'h033,
        CSR_TID    = 14'h040,
        CSR_TCFG   = 14'h041,
        CSR_TVAL   = 14'h042,
        CSR_CNTC   = 14'h043,
        CSR_TICLR  = 14'h044
    } csr_addr_e;

    // crmd
    localparam int CRMD_PLV_LO = 0;
    localparam int CRMD_PLV_W  = 2;
    localparam int CRMD_IE_LO  = 2;
    localparam int CRMD_IE_W   = 1;
    localparam int CRMD_DA_LO  = 3;
    localparam int CRMD_DA_W   = 1;

    // prmd
    localparam int PRMD_PPLV_LO = 0;
    localparam int PRMD_PPLV_W  = 2;
    localparam int PRMD_PIE_LO  = 2;
    localparam int PRMD_PIE_W   = 1;

    localparam int ECTL_LIE_LO = 0;
    localparam int ECTL_LIE_W  = 13;

    // estat
    localparam int ESTAT_IS_LO       = 0;
    localparam int ESTAT_IS_W        = 13;
    localparam int ESTAT_SWI_LO      = 0;
    localparam int ESTAT_SWI_W       = 2;
    localparam int ESTAT_HWI_LO      = 2;
    localparam int ESTAT_HWI_W       = 9;
    localparam int ESTAT_TI_LO       = 11;
    localparam int ESTAT_TI_W        = 1;
    localparam int ESTAT_ECODE_LO    = 16;
    localparam int ESTAT_ECODE_W     = 6;
    localparam int ESTAT_ESUBCODE_LO = 22;
    localparam int ESTAT_ESUBCODE_W  = 9;

    // timer config
    localparam int TCFG_EN_LO       = 0;
    localparam int TCFG_EN_W        = 1;
    localparam int TCFG_PERIODIC_LO = 1;
    localparam int TCFG_PERIODIC_W  = 1;
    localparam int TCFG_INITVAL_LO  = 2;
    localparam int TCFG_INITVAL_W   = 30;

    localparam int TICLR_CLR_LO = 0;
    localparam int TICLR_CLR_W  = 1;

    localparam int EENTRY_VA_LO = 6;
    localparam int EENTRY_VA_W  = 26;

    // direct address mode after reset
    localparam logic [CSR_W-1:0] CRMD_RESET = 32'h0000_0008;

    typedef struct packed {
        logic                we;
        csr_addr_e           addr;
        logic [CSR_W-1:0]    data;
    } csr_write_t;

    typedef struct packed {
        logic                          excp;
        logic                          ertn;
        logic [ESTAT_ECODE_W-1:0]      ecode;
        logic [ESTAT_ESUBCODE_W-1:0]   esubcode;
        logic [CSR_W-1:0]              era;
    } trap_event_t;

    typedef struct packed {
        logic [CSR_W-1:0]              crmd;
        logic [CSR_W-1:0]              prmd;
        logic [CSR_W-1:0]              ectl;
        logic [ESTAT_IS_W-1:0]         estat_lo;
        logic [ESTAT_ECODE_W-1:0]      ecode;
        logic [ESTAT_ESUBCODE_W-1:0]   esubcode;
        logic [CSR_W-1:0]              era;
        logic [CSR_W-1:0]              eentry;
        logic [3:0][CSR_W-1:0]         save;
    } trap_state_t;

    typedef struct packed {
        logic [CSR_W-1:0]    tcfg;
        logic [CSR_W-1:0]    tval;
        logic                ti;
        logic [CSR_W-1:0]    tid;
        logic [CSR_W-1:0]    cntc;
        logic [63:0]         stable;
    } timer_state_t;

endpackage

// ==== src/csr_read_mux.sv ====
module csr_read_mux
    import csr_pkg::*;
(
    input  logic [CSR_ADDR_W-1:0] raddr_i,
    input  trap_state_t           trap_i,
    input  timer_state_t          timer_i,
    input  logic                  excp_i,
    input  logic                  ertn_i,
    output logic [CSR_W-1:0]      rdata_o,
    output logic                  has_int_o,
    output logic [1:0]            plv_o,
    output logic [63:0]           stable_o
);

    logic [ESTAT_IS_W-1:0] is_bits;
    logic [CSR_W-1:0]      estat;

    // timer interrupt merged into IS
    always_comb begin
        is_bits = trap_i.estat_lo;
        is_bits[ESTAT_TI_LO +: ESTAT_TI_W] = timer_i.ti;
        estat = '0;
        estat[ESTAT_IS_LO +: ESTAT_IS_W]             = is_bits;
        estat[ESTAT_ECODE_LO +: ESTAT_ECODE_W]       = trap_i.ecode;
        estat[ESTAT_ESUBCODE_LO +: ESTAT_ESUBCODE_W] = trap_i.esubcode;
    end

    always_comb begin
        case (raddr_i)
            CSR_CRMD:   rdata_o = trap_i.crmd;
            CSR_PRMD:   rdata_o = trap_i.prmd;
            CSR_ECTL:   rdata_o = trap_i.ectl;
            CSR_ESTAT:  rdata_o = estat;
            CSR_ERA:    rdata_o = trap_i.era;
            CSR_EENTRY: rdata_o = trap_i.eentry;
            CSR_SAVE0:  rdata_o = trap_i.save[0];
            CSR_SAVE1:  rdata_o = trap_i.save[1];
            CSR_SAVE2:  rdata_o = trap_i.save[2];
            CSR_SAVE3:  rdata_o = trap_i.save[3];
            CSR_TID:    rdata_o = timer_i.tid;
            CSR_TCFG:   rdata_o = timer_i.tcfg;
            CSR_TVAL:   rdata_o = timer_i.tval;
            CSR_CNTC:   rdata_o = timer_i.cntc;
            // ticlr and unknown addresses read zero
            default:    rdata_o = '0;
        endcase
    end

    assign has_int_o = ((trap_i.ectl[ECTL_LIE_LO +: ECTL_LIE_W] & is_bits) != '0)
                       && trap_i.crmd[CRMD_IE_LO +: CRMD_IE_W] != '0;

    // privilege seen by the pipeline during a flush
    always_comb begin
        if (excp_i) begin
            plv_o = 2'b00;
        end else if (ertn_i) begin
            plv_o = trap_i.prmd[PRMD_PPLV_LO +: PRMD_PPLV_W];
        end else begin
            plv_o = trap_i.crmd[CRMD_PLV_LO +: CRMD_PLV_W];
        end
    end

    assign stable_o = timer_i.stable + {{32{timer_i.cntc[CSR_W-1]}}, timer_i.cntc};

endmodule

// ==== src/csr_timer.sv ====
module csr_timer
    import csr_pkg::*;
(
    input  logic         clk,
    input  logic         rst,
    input  csr_write_t   wr_i,
    output timer_state_t state_o
);

    logic [CSR_W-1:0] tcfg_q;
    logic [CSR_W-1:0] tval_q;
    logic [CSR_W-1:0] tid_q;
    logic [CSR_W-1:0] cntc_q;
    logic [63:0]      stable_q;
    logic             timer_en;
    logic             ti_q;
    logic             tcfg_we;
    logic             ticlr_clr;
    logic             timeout;
    logic             periodic;

    assign tcfg_we   = wr_i.we && (wr_i.addr == CSR_TCFG);
    assign ticlr_clr = wr_i.we && (wr_i.addr == CSR_TICLR)
                       && wr_i.data[TICLR_CLR_LO +: TICLR_CLR_W] != '0;
    assign timeout   = timer_en && (tval_q == '0);
    assign periodic  = tcfg_q[TCFG_PERIODIC_LO +: TCFG_PERIODIC_W] != '0;

    always_ff @(posedge clk) begin
        if (rst) begin
            tcfg_q <= '0;
        end else if (tcfg_we) begin
            tcfg_q <= wr_i.data;
        end
    end

    // countdown with reload of initval times four
    always_ff @(posedge clk) begin
        if (rst) begin
            timer_en <= 1'b0;
            tval_q   <= '0;
        end else if (tcfg_we) begin
            timer_en <= wr_i.data[TCFG_EN_LO +: TCFG_EN_W] != '0;
            tval_q   <= {wr_i.data[TCFG_INITVAL_LO +: TCFG_INITVAL_W], 2'b00};
        end else if (timeout) begin
            timer_en <= periodic;
            tval_q   <= periodic ? {tcfg_q[TCFG_INITVAL_LO +: TCFG_INITVAL_W], 2'b00} : '1;
        end else if (timer_en) begin
            tval_q <= tval_q - 1'b1;
        end
    end

    // clear wins over a new timeout
    always_ff @(posedge clk) begin
        if (rst) begin
            ti_q <= 1'b0;
        end else if (ticlr_clr) begin
            ti_q <= 1'b0;
        end else if (timeout) begin
            ti_q <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            stable_q <= '0;
            cntc_q   <= '0;
            tid_q    <= '0;
        end else begin
            stable_q <= stable_q + 64'd1;
            if (wr_i.we && wr_i.addr == CSR_CNTC) begin
                cntc_q <= wr_i.data;
            end
            if (wr_i.we && wr_i.addr == CSR_TID) begin
                tid_q <= wr_i.data;
            end
        end
    end

    assign state_o = '{
        tcfg:   tcfg_q,
        tval:   tval_q,
        ti:     ti_q,
        tid:    tid_q,
        cntc:   cntc_q,
        stable: stable_q
    };

endmodule

// ==== src/csr_trap_regs.sv ====
module csr_trap_regs
    import csr_pkg::*;
(
    input  logic        clk,
    input  logic        rst,
    input  csr_write_t  wr_i,
    input  trap_event_t trap_i,
    input  logic [8:0]  hw_int_i,
    output trap_state_t state_o
);

    logic [CSR_W-1:0]            crmd_q;
    logic [CSR_W-1:0]            prmd_q;
    logic [CSR_W-1:0]            ectl_q;
    logic [ESTAT_SWI_W-1:0]      swi_q;
    logic [ESTAT_HWI_W-1:0]      hwi_q;
    logic [ESTAT_ECODE_W-1:0]    ecode_q;
    logic [ESTAT_ESUBCODE_W-1:0] esubcode_q;
    logic [CSR_W-1:0]            era_q;
    logic [EENTRY_VA_W-1:0]      eentry_va_q;
    logic [3:0][CSR_W-1:0]       save_q;

    function automatic logic hit(csr_write_t wr, csr_addr_e addr);
        return wr.we && (wr.addr == addr);
    endfunction

    // crmd
    always_ff @(posedge clk) begin
        if (rst) begin
            crmd_q <= CRMD_RESET;
        end else if (trap_i.excp) begin
            crmd_q[CRMD_PLV_LO +: CRMD_PLV_W] <= '0;
            crmd_q[CRMD_IE_LO +: CRMD_IE_W]   <= '0;
        end else if (trap_i.ertn) begin
            crmd_q[CRMD_PLV_LO +: CRMD_PLV_W] <= prmd_q[PRMD_PPLV_LO +: PRMD_PPLV_W];
            crmd_q[CRMD_IE_LO +: CRMD_IE_W]   <= prmd_q[PRMD_PIE_LO +: PRMD_PIE_W];
        end else if (hit(wr_i, CSR_CRMD)) begin
            crmd_q[CRMD_PLV_LO +: CRMD_PLV_W] <= wr_i.data[CRMD_PLV_LO +: CRMD_PLV_W];
            crmd_q[CRMD_IE_LO +: CRMD_IE_W]   <= wr_i.data[CRMD_IE_LO +: CRMD_IE_W];
            crmd_q[CRMD_DA_LO +: CRMD_DA_W]   <= wr_i.data[CRMD_DA_LO +: CRMD_DA_W];
        end
    end

    // prmd keeps the state interrupted by the exception
    always_ff @(posedge clk) begin
        if (rst) begin
            prmd_q <= '0;
        end else if (trap_i.excp) begin
            prmd_q[PRMD_PPLV_LO +: PRMD_PPLV_W] <= crmd_q[CRMD_PLV_LO +: CRMD_PLV_W];
            prmd_q[PRMD_PIE_LO +: PRMD_PIE_W]   <= crmd_q[CRMD_IE_LO +: CRMD_IE_W];
        end else if (hit(wr_i, CSR_PRMD)) begin
            prmd_q[PRMD_PPLV_LO +: PRMD_PPLV_W] <= wr_i.data[PRMD_PPLV_LO +: PRMD_PPLV_W];
            prmd_q[PRMD_PIE_LO +: PRMD_PIE_W]   <= wr_i.data[PRMD_PIE_LO +: PRMD_PIE_W];
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            ectl_q <= '0;
        end else if (hit(wr_i, CSR_ECTL)) begin
            ectl_q[ECTL_LIE_LO +: ECTL_LIE_W] <= wr_i.data[ECTL_LIE_LO +: ECTL_LIE_W];
        end
    end

    // estat sw bits, sampled hw lines and exception code
    always_ff @(posedge clk) begin
        if (rst) begin
            swi_q      <= '0;
            hwi_q      <= '0;
            ecode_q    <= '0;
            esubcode_q <= '0;
        end else begin
            hwi_q <= hw_int_i;
            if (trap_i.excp) begin
                ecode_q    <= trap_i.ecode;
                esubcode_q <= trap_i.esubcode;
            end else if (hit(wr_i, CSR_ESTAT)) begin
                swi_q <= wr_i.data[ESTAT_SWI_LO +: ESTAT_SWI_W];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (trap_i.excp) begin
            era_q <= trap_i.era;
        end else if (hit(wr_i, CSR_ERA)) begin
            era_q <= wr_i.data;
        end
    end

    always_ff @(posedge clk) begin
        if (hit(wr_i, CSR_EENTRY)) begin
            eentry_va_q <= wr_i.data[EENTRY_VA_LO +: EENTRY_VA_W];
        end
    end

    // scratch registers
    always_ff @(posedge clk) begin
        if (wr_i.we) begin
            case (wr_i.addr)
                CSR_SAVE0: save_q[0] <= wr_i.data;
                CSR_SAVE1: save_q[1] <= wr_i.data;
                CSR_SAVE2: save_q[2] <= wr_i.data;
                CSR_SAVE3: save_q[3] <= wr_i.data;
                default: ;
            endcase
        end
    end

    always_comb begin
        state_o          = '0;
        state_o.crmd     = crmd_q;
        state_o.prmd     = prmd_q;
        state_o.ectl     = ectl_q;
        // bit 11 belongs to the timer
        state_o.estat_lo[ESTAT_SWI_LO +: ESTAT_SWI_W] = swi_q;
        state_o.estat_lo[ESTAT_HWI_LO +: ESTAT_HWI_W] = hwi_q;
        state_o.ecode    = ecode_q;
        state_o.esubcode = esubcode_q;
        state_o.era      = era_q;
        state_o.eentry[EENTRY_VA_LO +: EENTRY_VA_W] = eentry_va_q;
        state_o.save     = save_q;
    end

endmodule

// ==== src/csr_write_arbiter.sv ====
module csr_write_arbiter
    import csr_pkg::*;
(
    input  csr_write_t wr_a_i,
    input  csr_write_t wr_b_i,
    output csr_write_t wr_o
);

    csr_write_t pick;
    logic       addr_ok;

    // port 1 first
    always_comb begin
        if (wr_a_i.we) begin
            pick = wr_a_i;
        end else if (wr_b_i.we) begin
            pick = wr_b_i;
        end else begin
            pick = '{we: 1'b0, addr: CSR_CRMD, data: '0};
        end
    end

    always_comb begin
        case (pick.addr)
            CSR_CRMD, CSR_PRMD, CSR_ECTL, CSR_ESTAT, CSR_ERA, CSR_EENTRY,
            CSR_SAVE0, CSR_SAVE1, CSR_SAVE2, CSR_SAVE3,
            CSR_TID, CSR_TCFG, CSR_TVAL, CSR_CNTC, CSR_TICLR: addr_ok = 1'b1;
            default: addr_ok = 1'b0;
        endcase
    end

    // unknown targets turn into an idle write
    assign wr_o = '{we: pick.we & addr_ok, addr: pick.addr, data: pick.data};

endmodule
